//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_motion_controller
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/command_decoder.sv
// Host command decoder with word edge detect, move buffer, enable and divisor registers
`timescale 1ns/100ps
`include "motion_macros.svh"

module command_decoder (
  input  logic                      CLK,
  input  logic                      resetn,
  input  motion_pkg::word_t         word_data,
  input  logic                      word_received,
  input  motion_pkg::slot_t         move_index,
  input  motion_pkg::step_count_t   step_counts [`NUM_MOTORS],
  input  logic [`BUFFER_SIZE-1:0]   slot_ack,
  output motion_pkg::word_t         word_reply,
  output logic [`BUFFER_SIZE-1:0]   stepready,
  output logic                      buffer_dtr,
  output logic [`DIVISOR_BITS-1:0]  clock_divisor,
  output motion_pkg::duration_t     move_duration,
  output motion_pkg::dda_t          velocity [`NUM_MOTORS],
  output motion_pkg::dda_t          acceleration [`NUM_MOTORS],
  output motion_pkg::axis_vec_t     move_dir,
  output motion_pkg::axis_vec_t     enable_r
);

  import motion_pkg::*;

  // Header, duration, then velocity and acceleration per axis
  localparam logic [7:0] LAST_WORD = 8'(2 * `NUM_MOTORS + 1);

  logic       recv_q;
  logic       recv_qq;
  logic       word_rise;
  logic [7:0] message_header;
  logic [7:0] message_word_count;
  logic       awaiting_more;
  logic       move_complete;
  cmd_t       header_cmd;
  slot_t      write_index;

  // Move buffer
  duration_t   dur_buf [`BUFFER_SIZE];
  dda_t        vel_buf [`BUFFER_SIZE][`NUM_MOTORS];
  dda_t        acc_buf [`BUFFER_SIZE][`NUM_MOTORS];
  axis_vec_t   dir_buf [`BUFFER_SIZE];
  step_count_t step_store [`NUM_MOTORS];   // Counts taken at the move header

  always_ff @(posedge CLK) begin
    if (resetn) begin
      recv_q  <= 1'b0;
      recv_qq <= 1'b0;
    end else begin
      recv_q  <= word_received;
      recv_qq <= recv_q;
    end
  end

  assign word_rise     = recv_q & ~recv_qq;
  assign header_cmd    = cmd_t'(word_data[`WORD_BITS-1 -: 8]);   // Header is the top byte
  assign awaiting_more = (message_header == CMD_COORDINATED_STEP);
  assign move_complete = word_rise && awaiting_more && (message_word_count == LAST_WORD);

  // Command decode, control registers and replies
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_reply         <= '0;
      message_header     <= '0;
      message_word_count <= '0;
      write_index        <= '0;
      stepready          <= '0;
      enable_r           <= '0;
      clock_divisor      <= `DEFAULT_CLOCK_DIVISOR;
      for (int s = 0; s < `BUFFER_SIZE; s++) begin
        dir_buf[s] <= '0;
      end
    end else if (word_rise) begin
      word_reply <= '0;
      if (!awaiting_more) begin
        message_header     <= header_cmd;
        message_word_count <= 8'd1;
        case (header_cmd)
          CMD_COORDINATED_STEP: dir_buf[write_index] <= word_data[`NUM_MOTORS-1:0];
          CMD_MOTOR_ENABLE:     enable_r <= word_data[`NUM_MOTORS-1:0];
          CMD_CLK_DIVISOR:      clock_divisor <= word_data[`DIVISOR_BITS-1:0];
          CMD_API_VERSION: begin
            word_reply[31:0] <= {`VERSION_DEVEL, `VERSION_MAJOR, `VERSION_MINOR,
                                 `VERSION_PATCH};
          end
          CMD_CHANNEL_INFO:     word_reply[7:0] <= 8'(`NUM_MOTORS);
          default: ;
        endcase
      end else begin
        message_word_count <= message_word_count + 8'd1;
        // Duration word returns axis 0, each acceleration word the next axis
        if (message_word_count == 8'd1) begin
          word_reply[`STEP_COUNT_BITS-1:0] <= step_store[0];
        end
        for (int n = 0; n < `NUM_MOTORS - 1; n++) begin
          if (message_word_count == 8'(2 * n + 3)) begin
            word_reply[`STEP_COUNT_BITS-1:0] <= step_store[n + 1];
          end
        end
        if (move_complete) begin
          write_index            <= write_index + 1'b1;
          stepready[write_index] <= ~stepready[write_index];   // Hand slot to sequencer
          message_header         <= '0;
          message_word_count     <= '0;
        end
      end
    end
  end

  // Move payload and position snapshots
  always_ff @(posedge CLK) begin
    if (word_rise && !awaiting_more && (header_cmd == CMD_COORDINATED_STEP)) begin
      for (int n = 0; n < `NUM_MOTORS; n++) begin
        step_store[n] <= step_counts[n];
      end
    end
    if (word_rise && awaiting_more) begin
      if (message_word_count == 8'd1) begin
        dur_buf[write_index] <= word_data[`MOVE_DURATION_BITS-1:0];
      end
      for (int n = 0; n < `NUM_MOTORS; n++) begin
        if (message_word_count == 8'(2 * n + 2)) begin
          vel_buf[write_index][n] <= word_data;
        end
        if (message_word_count == 8'(2 * n + 3)) begin
          acc_buf[write_index][n] <= word_data;
        end
      end
    end
  end

  assign buffer_dtr    = (stepready[write_index] == slot_ack[write_index]);
  assign move_duration = dur_buf[move_index];
  assign move_dir      = dir_buf[move_index];

  // Slot selected by the sequencer feeds the timers
  for (genvar n = 0; n < `NUM_MOTORS; n++) begin : g_axis_sel
    assign velocity[n]     = vel_buf[move_index][n];
    assign acceleration[n] = acc_buf[move_index][n];
  end

  // Host waits for buffer_dtr, so a finished move never lands in a busy slot
  a_no_overwrite: assert property (@(posedge CLK) disable iff (resetn)
    move_complete |-> (stepready[write_index] == slot_ack[write_index]));

endmodule

//--- rtl/dda_timer.sv
// Second-order DDA for one axis that turns velocity and acceleration into a step level
`timescale 1ns/100ps
`include "motion_macros.svh"

module dda_timer (
  input  logic              CLK,
  input  logic              resetn,
  input  logic              dda_tick,
  input  logic              loading_move,
  input  logic              executing_move,
  input  motion_pkg::dda_t  velocity,
  input  motion_pkg::dda_t  acceleration,
  output logic              step_level
);

  import motion_pkg::*;

  dda_t accum;   // Position phase
  dda_t rate;    // Current velocity

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum <= '0;
      rate  <= '0;
    end else if (dda_tick && loading_move) begin
      accum <= '0;
      rate  <= velocity;
    end else if (dda_tick && executing_move) begin
      // Position uses the rate from before this tick's acceleration
      accum <= accum + rate;
      rate  <= rate + acceleration;
    end
  end

  // Top bit toggles once per step period
  assign step_level = accum[`DDA_BITS-1];

endmodule

//--- rtl/motion_controller_top.sv
// Motion controller top with decoder, sequencer, per-axis DDA timers and step tracker
`timescale 1ns/100ps
`include "motion_macros.svh"

module motion_controller_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  motion_pkg::word_t      word_data,
  input  logic                   word_received,
  output motion_pkg::word_t      word_reply,
  output logic                   buffer_dtr,
  output logic                   move_done,
  output motion_pkg::axis_vec_t  step,
  output motion_pkg::axis_vec_t  dir,
  output motion_pkg::axis_vec_t  enable
);

  import motion_pkg::*;

  logic [`BUFFER_SIZE-1:0]  stepready;
  logic [`BUFFER_SIZE-1:0]  slot_ack;
  slot_t                    move_index;
  logic [`DIVISOR_BITS-1:0] clock_divisor;
  duration_t                move_duration;
  dda_t                     velocity [`NUM_MOTORS];
  dda_t                     acceleration [`NUM_MOTORS];
  axis_vec_t                move_dir;
  axis_vec_t                enable_r;
  axis_vec_t                step_levels;
  step_count_t              step_counts [`NUM_MOTORS];
  logic                     dda_tick;
  logic                     loading_move;
  logic                     executing_move;

  command_decoder u_decoder (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_data     (word_data),
    .word_received (word_received),
    .move_index    (move_index),
    .step_counts   (step_counts),
    .slot_ack      (slot_ack),
    .word_reply    (word_reply),
    .stepready     (stepready),
    .buffer_dtr    (buffer_dtr),
    .clock_divisor (clock_divisor),
    .move_duration (move_duration),
    .velocity      (velocity),
    .acceleration  (acceleration),
    .move_dir      (move_dir),
    .enable_r      (enable_r)
  );

  move_sequencer u_sequencer (
    .CLK            (CLK),
    .resetn         (resetn),
    .clock_divisor  (clock_divisor),
    .move_duration  (move_duration),
    .stepready      (stepready),
    .slot_ack       (slot_ack),
    .move_index     (move_index),
    .dda_tick       (dda_tick),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .move_done      (move_done)
  );

  // One timer per axis, all sharing the sequencer's tick
  for (genvar a = 0; a < `NUM_MOTORS; a++) begin : g_axis
    dda_timer u_dda (
      .CLK            (CLK),
      .resetn         (resetn),
      .dda_tick       (dda_tick),
      .loading_move   (loading_move),
      .executing_move (executing_move),
      .velocity       (velocity[a]),
      .acceleration   (acceleration[a]),
      .step_level     (step_levels[a])
    );
  end

  step_tracker u_tracker (
    .CLK         (CLK),
    .resetn      (resetn),
    .step_levels (step_levels),
    .move_dir    (move_dir),
    .enable_r    (enable_r),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .step_counts (step_counts)
  );

endmodule

//--- rtl/motion_macros.svh
// Widths, axis count, move buffer size, default DDA divisor and API version numbers
`ifndef MOTION_MACROS_SVH
`define MOTION_MACROS_SVH

// Host word port
`define WORD_BITS 64

// Axes and move buffer
`define NUM_MOTORS   3
`define BUFFER_SIZE  2
`define BUF_IDX_BITS 1   // Enough to index BUFFER_SIZE slots

// DDA and move timing
`define DDA_BITS              64
`define MOVE_DURATION_BITS    32
`define STEP_COUNT_BITS       32
`define DIVISOR_BITS          8
`define DEFAULT_CLOCK_DIVISOR 8'd32

// API version returned to the host
`define VERSION_MAJOR 8'd1
`define VERSION_MINOR 8'd2
`define VERSION_PATCH 8'd0
`define VERSION_DEVEL 8'd0

`endif

//--- rtl/motion_pkg.sv
// Command header codes and the shared word, rate, duration, position, axis and slot types
`include "motion_macros.svh"

package motion_pkg;

  // Command header, top byte of the first word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0A,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_CHANNEL_INFO     = 8'hFD,
    CMD_API_VERSION      = 8'hFE
  } cmd_t;

  typedef logic [`WORD_BITS-1:0] word_t;

  // Rate or position accumulator of one DDA
  typedef logic signed [`DDA_BITS-1:0] dda_t;

  typedef logic [`MOVE_DURATION_BITS-1:0] duration_t;   // Move length in DDA ticks

  typedef logic signed [`STEP_COUNT_BITS-1:0] step_count_t;

  typedef logic [`NUM_MOTORS-1:0] axis_vec_t;   // One bit per axis

  typedef logic [`BUF_IDX_BITS-1:0] slot_t;

endpackage

//--- rtl/move_sequencer.sv
// DDA tick divider and the idle, load and execute FSM over the move buffer slots
`timescale 1ns/100ps
`include "motion_macros.svh"

module move_sequencer (
  input  logic                      CLK,
  input  logic                      resetn,
  input  logic [`DIVISOR_BITS-1:0]  clock_divisor,
  input  motion_pkg::duration_t     move_duration,
  input  logic [`BUFFER_SIZE-1:0]   stepready,
  output logic [`BUFFER_SIZE-1:0]   slot_ack,
  output motion_pkg::slot_t         move_index,
  output logic                      dda_tick,
  output logic                      loading_move,
  output logic                      executing_move,
  output logic                      move_done
);

  import motion_pkg::*;

  localparam logic [`DIVISOR_BITS-1:0] MIN_DIVISOR = 2;

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_EXEC} seq_state_t;

  seq_state_t               state;
  logic [`DIVISOR_BITS-1:0] div_count;
  duration_t                elapsed;   // Ticks run in the current move
  logic                     slot_full;

  // One tick every clock_divisor cycles
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_count <= '0;
      dda_tick  <= 1'b0;
    end else if (div_count >= clock_divisor - 1'b1) begin
      div_count <= '0;
      dda_tick  <= 1'b1;
    end else begin
      div_count <= div_count + 1'b1;
      dda_tick  <= 1'b0;
    end
  end

  assign slot_full      = (stepready[move_index] != slot_ack[move_index]);
  assign loading_move   = (state == S_LOAD) && dda_tick;
  assign executing_move = (state == S_EXEC);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= S_IDLE;
      elapsed    <= '0;
      slot_ack   <= '0;
      move_index <= '0;
      move_done  <= 1'b0;
    end else begin
      move_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (slot_full) begin
            state <= S_LOAD;
          end
        end
        S_LOAD: begin
          if (dda_tick) begin   // Timers load on this tick
            state   <= S_EXEC;
            elapsed <= '0;
          end
        end
        S_EXEC: begin
          if (elapsed == move_duration) begin
            state                <= S_IDLE;
            move_done            <= 1'b1;
            slot_ack[move_index] <= ~slot_ack[move_index];   // Free the slot
            move_index           <= move_index + 1'b1;
          end else if (dda_tick) begin
            elapsed <= elapsed + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Ticks must be spaced so the end check never shares a cycle with a tick
  a_divisor_min: assert property (@(posedge CLK) disable iff (resetn)
    clock_divisor >= MIN_DIVISOR);

  // Running slot keeps its duration, or the tick count overruns it
  a_elapsed_bound: assert property (@(posedge CLK) disable iff (resetn)
    executing_move |-> (elapsed <= move_duration));

endmodule

//--- rtl/step_tracker.sv
// Step, direction and enable outputs plus signed per-axis step counters
`timescale 1ns/100ps
`include "motion_macros.svh"

module step_tracker (
  input  logic                     CLK,
  input  logic                     resetn,
  input  motion_pkg::axis_vec_t    step_levels,
  input  motion_pkg::axis_vec_t    move_dir,
  input  motion_pkg::axis_vec_t    enable_r,
  output motion_pkg::axis_vec_t    step,
  output motion_pkg::axis_vec_t    dir,
  output motion_pkg::axis_vec_t    enable,
  output motion_pkg::step_count_t  step_counts [`NUM_MOTORS]
);

  import motion_pkg::*;

  axis_vec_t step_rise;

  // Registered step output doubles as the previous level
  assign step_rise = step_levels & ~step;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      step   <= '0;
      dir    <= '0;
      enable <= '0;
      for (int n = 0; n < `NUM_MOTORS; n++) begin
        step_counts[n] <= '0;
      end
    end else begin
      step   <= step_levels;
      dir    <= move_dir;
      enable <= enable_r;
      for (int n = 0; n < `NUM_MOTORS; n++) begin
        if (step_rise[n]) begin
          if (move_dir[n]) begin
            step_counts[n] <= step_counts[n] + 1'b1;   // Positive direction
          end else begin
            step_counts[n] <= step_counts[n] - 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- tb.f
+incdir+rtl
rtl/motion_pkg.sv
rtl/dda_timer.sv
rtl/step_tracker.sv
rtl/move_sequencer.sv
rtl/command_decoder.sv
rtl/motion_controller_top.sv
verif/tb_motion_controller.sv

//--- verif/tb_motion_controller.sv
// Testbench for the motion controller with a host word table, DDA step model and watchdog
`timescale 1ns/100ps
`include "motion_macros.svh"

module tb_motion_controller;

  localparam int MAX_WORDS = 48;
  localparam int FAST_DIV  = 4;
  localparam int FAST_DUR  = 40;
  localparam logic [`NUM_MOTORS-1:0] PAIR_DIRS = 3'b010;   // First move of the pair

  logic                   CLK;
  logic                   resetn;
  logic [`WORD_BITS-1:0]  word_data;
  logic                   word_received;
  logic [`WORD_BITS-1:0]  word_reply;
  logic                   buffer_dtr;
  logic                   move_done;
  logic [`NUM_MOTORS-1:0] step;
  logic [`NUM_MOTORS-1:0] dir;
  logic [`NUM_MOTORS-1:0] enable;

  // Host word table
  logic [63:0] tab_word [MAX_WORDS];
  logic [63:0] tab_reply [MAX_WORDS];
  logic        tab_chk [MAX_WORDS];    // Reply is compared
  logic        tab_dtr [MAX_WORDS];    // Wait for buffer_dtr first
  int          tab_done [MAX_WORDS];   // Moves retired before sending
  int          n_words;

  int          model_count [`NUM_MOTORS];
  int          cur_div;
  longint      est_cycles;
  longint      watch_cycles;
  logic [31:0] lfsr_state;
  int          fail_count;
  int          cycle;
  int          done_count;
  int          last_done_cycle;
  int          strobe_cycle;
  logic        done_prev;
  int          mark_ids;
  int          mark_pair;

  motion_controller_top UUT (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_data     (word_data),
    .word_received (word_received),
    .word_reply    (word_reply),
    .buffer_dtr    (buffer_dtr),
    .move_done     (move_done),
    .step          (step),
    .dir           (dir),
    .enable        (enable)
  );

  always #5 CLK = ~CLK;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      fail_count++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // Rising top-bit transitions of a second-order DDA over dur ticks
  function automatic int count_rises(input logic signed [63:0] vel,
                                     input logic signed [63:0] acc, input int dur);
    logic signed [63:0] pos;
    logic signed [63:0] rate;
    logic               prev;
    int                 rises;
    pos   = '0;
    rate  = vel;
    rises = 0;
    for (int t = 0; t < dur; t++) begin
      prev = pos[63];
      pos  = pos + rate;   // Old rate first, then acceleration
      rate = rate + acc;
      if (pos[63] && !prev) rises++;
    end
    return rises;
  endfunction

  task automatic push_word(input logic [63:0] w, input logic [63:0] r, input logic chk,
                           input logic dtr, input int need);
    tab_word[n_words]  = w;
    tab_reply[n_words] = r;
    tab_chk[n_words]   = chk;
    tab_dtr[n_words]   = dtr;
    tab_done[n_words]  = need;
    n_words++;
    est_cycles += 4;
  endtask

  // One coordinated move; snapshots expect the counts after all earlier moves
  task automatic build_move(input logic [`NUM_MOTORS-1:0] dirs, input int dur,
                            input logic accel, input logic chk, input int need);
    logic [63:0] vel [`NUM_MOTORS];
    logic [63:0] acc [`NUM_MOTORS];
    logic [63:0] snap [`NUM_MOTORS];
    logic [63:0] bits;
    int          rises;
    for (int n = 0; n < `NUM_MOTORS; n++) begin
      bits = take_bits(24);
      vel[n] = (64'h1 << 60) + (bits << 36);   // 1/16 to 1/8 step per tick
      acc[n] = '0;
      if (accel) begin
        bits = take_bits(20);
        acc[n] = (bits + 64'h1) << 34;
      end
      snap[n] = {32'h0, model_count[n]};
    end
    push_word((64'h01 << 56) | 64'(dirs), 64'h0, 1'b1, 1'b1, need);
    push_word(64'(dur), snap[0], chk, 1'b0, 0);
    for (int n = 0; n < `NUM_MOTORS; n++) begin
      push_word(vel[n], 64'h0, 1'b1, 1'b0, 0);
      if (n < `NUM_MOTORS - 1) push_word(acc[n], snap[n + 1], chk, 1'b0, 0);
      else push_word(acc[n], 64'h0, 1'b1, 1'b0, 0);
    end
    for (int n = 0; n < `NUM_MOTORS; n++) begin
      rises = count_rises(vel[n], acc[n], dur);
      model_count[n] = dirs[n] ? model_count[n] + rises : model_count[n] - rises;
    end
    est_cycles += (dur + 2) * cur_div;
  endtask

  task apply_words(input int first, input int last);
    for (int i = first; i < last; i++) begin
      while (done_count < tab_done[i]) begin
        @(posedge CLK);
        #1;
      end
      while (tab_dtr[i] && !buffer_dtr) begin
        @(posedge CLK);
        #1;
      end
      word_data     = tab_word[i];
      word_received = 1'b1;
      strobe_cycle  = cycle;
      repeat (2) @(posedge CLK);
      #1;
      word_received = 1'b0;
      repeat (2) @(posedge CLK);
      #1;
      if (tab_chk[i]) check_value($sformatf("reply to word %0d", i), word_reply, tab_reply[i]);
    end
  endtask

  // Counts cycles and move_done pulses
  always @(negedge CLK) begin
    cycle = cycle + 1;
    if (move_done === 1'b1) begin
      check_value("move_done high on consecutive cycles", {63'h0, done_prev}, 64'h0);
      done_count      = done_count + 1;
      last_done_cycle = cycle;
    end
    done_prev = move_done;
  end

  initial begin
    wait (watch_cycles > 0);
    #(watch_cycles * 10);
    $display("Watchdog expired: the run did not finish within %0d cycles", watch_cycles);
    $display("*** TEST FAILED ***");
    $fatal(1, "Timeout");
  end

  initial begin
    CLK           = 1'b0;
    resetn        = 1'b1;
    word_data     = '0;
    word_received = 1'b0;
    lfsr_state    = 32'h1a84;
    n_words       = 0;
    fail_count    = 0;
    cycle         = 0;
    done_count    = 0;
    done_prev     = 1'b0;
    watch_cycles  = 0;
    est_cycles    = 16;
    cur_div       = `DEFAULT_CLOCK_DIVISOR;
    for (int n = 0; n < `NUM_MOTORS; n++) model_count[n] = 0;

    push_word(64'hFE << 56, {32'h0, `VERSION_DEVEL, `VERSION_MAJOR, `VERSION_MINOR,
              `VERSION_PATCH}, 1'b1, 1'b0, 0);
    push_word(64'hFD << 56, 64'(`NUM_MOTORS), 1'b1, 1'b0, 0);
    push_word((64'h0A << 56) | 64'h5, 64'h0, 1'b1, 1'b0, 0);
    mark_ids = n_words;
    build_move(3'b101, 64, 1'b0, 1'b1, 0);   // Constant velocity, axis 1 backwards
    build_move(3'b111, 64, 1'b1, 1'b1, 1);
    build_move(PAIR_DIRS, 48, 1'b0, 1'b1, 2);
    build_move(3'b110, 48, 1'b1, 1'b0, 0);   // Back to back, snapshots taken mid-move
    mark_pair = n_words;
    push_word((64'h20 << 56) | 64'(FAST_DIV), 64'h0, 1'b1, 1'b0, 4);
    cur_div = FAST_DIV;
    build_move(3'b011, FAST_DUR, 1'b1, 1'b1, 4);
    watch_cycles = 2 * est_cycles;

    repeat (8) @(posedge CLK);
    #1;
    resetn = 1'b0;

    apply_words(0, mark_ids);
    check_value("enable port", 64'(enable), 64'h5);
    check_value("step while idle", 64'(step), 64'h0);

    apply_words(mark_ids, mark_pair);
    check_value("buffer_dtr with both slots full", {63'h0, buffer_dtr}, 64'h0);
    check_value("dir of the executing move", 64'(dir), 64'(PAIR_DIRS));
    while (done_count < 3) begin
      @(posedge CLK);
      #1;
    end
    check_value("buffer_dtr after first move retires", {63'h0, buffer_dtr}, 64'h1);

    apply_words(mark_pair, n_words);
    while (done_count < 5) begin
      @(posedge CLK);
      #1;
    end
    check_value("move time at fast divisor",
                {63'h0, (last_done_cycle - strobe_cycle) >= FAST_DUR * FAST_DIV}, 64'h1);

    repeat (2) @(posedge CLK);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("*** TEST FAILED ***");
      $fatal(1, "Checks failed");
    end
  end

endmodule
